/* fpga_rr_lite.f */
+incdir+common
common/rr_pkg.sv
common/rr_chan_if.sv
src/rr_log_fifo.sv
record/rr_channel_recorder.sv
record/rr_log_merge.sv
replay/rr_replayer.sv
src/rr_status.sv
src/rr_top.sv
bench/tb_rr_top.sv

/* Makefile */
# Verilator build and run for the record-and-replay shim

VERILATOR ?= verilator
TOP       ?= tb_rr_top
RTL_TOP   ?= rr_top
FLIST     ?= fpga_rr_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log is searched for the pass line to decide the result
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_rr_top.sv */
`timescale 1ns/1ps
`include "rr_defs.svh"

module tb_rr_top;
  import rr_pkg::*;

  localparam int unsigned SEED = 32'h267c_2f75;
  localparam int LOG_DEPTH = `RR_FIFO_DEPTH;
  localparam int PHASE_LIMIT = 5000;
  // Log ready modes
  localparam int LOG_RANDOM = 0;
  localparam int LOG_LOW = 1;
  localparam int LOG_HIGH = 2;

  logic                  clk;
  logic                  rstn;
  logic                  record_en;
  logic                  replay_en;
  logic                  status_clr;
  logic [2:0]            overflow;
  logic [2:0]            almful;
  logic [1:0]            sh_valid;
  logic [1:0]            sh_ready;
  logic [`RR_ADDR_W-1:0] sh_addr [2];
  logic [`RR_DATA_W-1:0] sh_data [2];
  logic [1:0]            cl_valid;
  logic [1:0]            cl_ready;
  logic [`RR_ADDR_W-1:0] cl_addr [2];
  logic [`RR_DATA_W-1:0] cl_data [2];
  logic                  log_valid;
  logic                  log_ready;
  logic                  log_chan;
  logic [`RR_ADDR_W-1:0] log_addr;
  logic [`RR_DATA_W-1:0] log_data;
  logic                  rp_valid;
  logic                  rp_ready;
  logic                  rp_chan;
  logic [`RR_ADDR_W-1:0] rp_addr;
  logic [`RR_DATA_W-1:0] rp_data;

  // Reference model of circuit transfers and log FIFO contents per channel
  rr_xfer_t   exp_cl_q [2][$];
  rr_xfer_t   log_q [2][$];
  rr_xfer_t   seen_xfer;
  rr_xfer_t   exp_xfer;
  // Stimulus knobs with rates in percent
  int         sh_left [2];
  int         rp_left;
  int         sh_pct;
  int         rp_pct;
  int         cl_pct;
  int         log_mode;
  int         log_low_run;
  logic [1:0] sh_done;
  logic       rp_done;
  int         errors;
  int         timeouts;

  rr_top i_rr_top (
    .clk(clk), .rstn(rstn),
    .i_record_en(record_en), .i_replay_en(replay_en), .i_status_clr(status_clr),
    .o_overflow(overflow), .o_almful(almful),
    .i_sh_a_valid(sh_valid[0]), .o_sh_a_ready(sh_ready[0]),
    .i_sh_a_addr(sh_addr[0]), .i_sh_a_data(sh_data[0]),
    .i_sh_b_valid(sh_valid[1]), .o_sh_b_ready(sh_ready[1]),
    .i_sh_b_addr(sh_addr[1]), .i_sh_b_data(sh_data[1]),
    .o_cl_a_valid(cl_valid[0]), .i_cl_a_ready(cl_ready[0]),
    .o_cl_a_addr(cl_addr[0]), .o_cl_a_data(cl_data[0]),
    .o_cl_b_valid(cl_valid[1]), .i_cl_b_ready(cl_ready[1]),
    .o_cl_b_addr(cl_addr[1]), .o_cl_b_data(cl_data[1]),
    .o_log_valid(log_valid), .i_log_ready(log_ready), .o_log_chan(log_chan),
    .o_log_addr(log_addr), .o_log_data(log_data),
    .i_rp_valid(rp_valid), .o_rp_ready(rp_ready), .i_rp_chan(rp_chan),
    .i_rp_addr(rp_addr), .i_rp_data(rp_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
      errors++;
    end
  endtask

  function automatic bit pct_hit(input int pct);
    return int'($urandom % 100) < pct;
  endfunction

  ////////////////////////////////////////
  // Monitor sampled on the rising edge
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rstn) begin
      for (int c = 0; c < 2; c++) begin
        if (cl_valid[c] && cl_ready[c]) begin
          seen_xfer.addr = cl_addr[c];
          seen_xfer.data = cl_data[c];
          if (exp_cl_q[c].size() == 0) begin
            $display("Circuit channel %0d transferred with nothing expected at %0t ns", c, $time);
            errors++;
          end else begin
            exp_xfer = exp_cl_q[c].pop_front();
            check_value(64'(seen_xfer), 64'(exp_xfer),
                        $sformatf("circuit channel %0d transfer", c));
            // Log FIFO holds 8 and drops a push when full
            if (record_en && log_q[c].size() < LOG_DEPTH) begin
              log_q[c].push_back(exp_xfer);
            end
          end
        end
        sh_done[c] = sh_valid[c] & sh_ready[c];
        if (!replay_en) begin
          check_value(64'(sh_ready[c]), 64'(cl_ready[c]), "shell ready vs circuit ready");
          check_value(64'(cl_valid[c]), 64'(sh_valid[c]), "circuit valid vs shell valid");
        end else begin
          check_value(64'(sh_ready[c]), 64'(0), "shell ready during replay");
        end
      end
      rp_done = rp_valid & rp_ready;
      if (!record_en) begin
        check_value(64'(log_valid), 64'(0), "log valid with record off");
      end
      if (log_valid && log_ready) begin
        if (log_q[log_chan].size() == 0) begin
          $display("Log entry for channel %0d appeared with nothing recorded at %0t ns",
                   log_chan, $time);
          errors++;
        end else begin
          check_value(64'({log_addr, log_data}), 64'(log_q[log_chan].pop_front()),
                      $sformatf("log entry on channel %0d", log_chan));
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus for one falling edge per call
  ////////////////////////////////////////
  task automatic step();
    rr_xfer_t x;
    for (int c = 0; c < 2; c++) begin
      // Valid and payload held until the transfer
      if (sh_valid[c] && sh_done[c]) begin
        sh_valid[c] = 1'b0;
      end
      if (!sh_valid[c] && sh_left[c] > 0 && pct_hit(sh_pct)) begin
        x.addr = `RR_ADDR_W'($urandom);
        x.data = $urandom;
        sh_addr[c] = x.addr;
        sh_data[c] = x.data;
        sh_valid[c] = 1'b1;
        sh_left[c]--;
        exp_cl_q[c].push_back(x);
      end
      cl_ready[c] = pct_hit(cl_pct);
    end
    if (rp_valid && rp_done) begin
      rp_valid = 1'b0;
    end
    // Replayed entry is expected on the circuit channel named by its tag
    if (!rp_valid && rp_left > 0 && pct_hit(rp_pct)) begin
      x.addr = `RR_ADDR_W'($urandom);
      x.data = $urandom;
      rp_chan = 1'($urandom);
      rp_addr = x.addr;
      rp_data = x.data;
      rp_valid = 1'b1;
      rp_left--;
      exp_cl_q[rp_chan].push_back(x);
    end
    case (log_mode)
      LOG_LOW:  log_ready = 1'b0;
      LOG_HIGH: log_ready = 1'b1;
      default: begin
        // Never low for more than 2 cycles in a row
        if (log_low_run < 2 && pct_hit(25)) begin
          log_ready = 1'b0;
          log_low_run++;
        end else begin
          log_ready = 1'b1;
          log_low_run = 0;
        end
      end
    endcase
  endtask

  function automatic bit phase_done(input bit drain_log);
    bit busy;
    busy = (sh_left[0] + sh_left[1] + rp_left) != 0 || sh_valid != 2'b00 || rp_valid;
    for (int c = 0; c < 2; c++) begin
      busy = busy || exp_cl_q[c].size() != 0 || (drain_log && log_q[c].size() != 0);
    end
    return !busy;
  endfunction

  task automatic end_run();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic run_phase(input string name, input bit drain_log);
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk);
      step();
      cyc++;
    end while (!phase_done(drain_log) && cyc < PHASE_LIMIT);
    if (!phase_done(drain_log)) begin
      $display("Timeout in the %s phase, traffic still outstanding after %0d cycles",
               name, cyc);
      timeouts++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  task automatic drive_test_sequence();
    // Reset values with the replay input still closed for one cycle
    check_value(64'(log_valid), 64'(0), "log valid after reset");
    check_value(64'(rp_ready), 64'(0), "replay ready in first cycle");
    check_value(64'(cl_valid), 64'(0), "circuit valids after reset");
    check_value(64'({overflow, almful}), 64'(0), "status after reset");
    @(negedge clk);
    check_value(64'(rp_ready), 64'(1), "replay ready in second cycle");

    // Pass-through with record and replay off
    sh_pct = 40;
    cl_pct = 60;
    sh_left = '{40, 40};
    run_phase("pass-through", 1'b0);
    if (timeouts != 0) return;

    // Recording with random log ready
    record_en = 1'b1;
    sh_pct = 25;
    cl_pct = 70;
    sh_left = '{60, 60};
    run_phase("recording", 1'b1);
    if (timeouts != 0) return;
    check_value(64'(overflow), 64'(0), "overflow after recording");

    // Log output stays quiet with record off
    record_en = 1'b0;
    sh_left = '{30, 30};
    run_phase("record off", 1'b1);
    if (timeouts != 0) return;

    // Overflow from 10 transfers on A into a stalled log
    record_en = 1'b1;
    log_mode = LOG_LOW;
    sh_pct = 100;
    cl_pct = 100;
    sh_left = '{10, 0};
    run_phase("overflow fill", 1'b0);
    if (timeouts != 0) return;
    check_value(64'(almful), 64'(3'b001), "almost-full after fill");
    check_value(64'(overflow), 64'(3'b001), "overflow after fill");

    // Queued entries stay put while record is off and log ready is high
    record_en = 1'b0;
    log_mode = LOG_HIGH;
    repeat (4) begin
      @(negedge clk);
      step();
    end
    record_en = 1'b1;
    run_phase("overflow drain", 1'b1);
    if (timeouts != 0) return;
    check_value(64'(overflow), 64'(3'b001), "sticky overflow after drain");
    check_value(64'(almful), 64'(0), "almost-full after drain");
    status_clr = 1'b1;
    @(negedge clk);
    status_clr = 1'b0;
    check_value(64'(overflow), 64'(0), "overflow after clear");

    // Replay with the shell side shut off
    record_en = 1'b0;
    log_mode = LOG_RANDOM;
    replay_en = 1'b1;
    rp_pct = 50;
    cl_pct = 70;
    rp_left = 60;
    run_phase("replay", 1'b0);
    if (timeouts != 0) return;

    // Replayed traffic is what gets recorded
    record_en = 1'b1;
    rp_left = 60;
    run_phase("replay record", 1'b1);
    if (timeouts != 0) return;
    check_value(64'(overflow), 64'(0), "overflow after replay");
  endtask

  initial begin
    rstn = 1'b0;
    record_en = 1'b0;
    replay_en = 1'b0;
    status_clr = 1'b0;
    sh_valid = 2'b00;
    cl_ready = 2'b00;
    sh_addr = '{'0, '0};
    sh_data = '{'0, '0};
    log_ready = 1'b0;
    rp_valid = 1'b0;
    rp_chan = 1'b0;
    rp_addr = '0;
    rp_data = '0;
    sh_done = 2'b00;
    rp_done = 1'b0;
    sh_left = '{0, 0};
    rp_left = 0;
    log_mode = LOG_RANDOM;
    log_low_run = 0;
    errors = 0;
    timeouts = 0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    drive_test_sequence();
    end_run();
  end
endmodule

/* src/rr_top.sv */
`timescale 1ns/1ps
`include "rr_defs.svh"

// Record-and-replay shim between the shell and the user circuit
module rr_top (
  input  logic                  clk,
  input  logic                  rstn,
  // Mode and status
  input  logic                  i_record_en,
  input  logic                  i_replay_en,
  input  logic                  i_status_clr,
  output logic [2:0]            o_overflow,
  output logic [2:0]            o_almful,
  // Shell channels
  input  logic                  i_sh_a_valid,
  output logic                  o_sh_a_ready,
  input  logic [`RR_ADDR_W-1:0] i_sh_a_addr,
  input  logic [`RR_DATA_W-1:0] i_sh_a_data,
  input  logic                  i_sh_b_valid,
  output logic                  o_sh_b_ready,
  input  logic [`RR_ADDR_W-1:0] i_sh_b_addr,
  input  logic [`RR_DATA_W-1:0] i_sh_b_data,
  // Circuit channels
  output logic                  o_cl_a_valid,
  input  logic                  i_cl_a_ready,
  output logic [`RR_ADDR_W-1:0] o_cl_a_addr,
  output logic [`RR_DATA_W-1:0] o_cl_a_data,
  output logic                  o_cl_b_valid,
  input  logic                  i_cl_b_ready,
  output logic [`RR_ADDR_W-1:0] o_cl_b_addr,
  output logic [`RR_DATA_W-1:0] o_cl_b_data,
  // Log output
  output logic                  o_log_valid,
  input  logic                  i_log_ready,
  output logic                  o_log_chan,
  output logic [`RR_ADDR_W-1:0] o_log_addr,
  output logic [`RR_DATA_W-1:0] o_log_data,
  // Replay input
  input  logic                  i_rp_valid,
  output logic                  o_rp_ready,
  input  logic                  i_rp_chan,
  input  logic [`RR_ADDR_W-1:0] i_rp_addr,
  input  logic [`RR_DATA_W-1:0] i_rp_data
);
  import rr_pkg::*;

  rr_chan_if sh_a_if ();
  rr_chan_if sh_b_if ();
  rr_chan_if rp_a_if ();
  rr_chan_if rp_b_if ();
  rr_chan_if cl_a_if ();
  rr_chan_if cl_b_if ();

  logic     [`RR_NUM_CHAN-1:0] rec_valid;
  rr_xfer_t [`RR_NUM_CHAN-1:0] rec_xfer;
  logic     [`RR_NUM_CHAN-1:0] rec_pop;
  rr_log_entry_t               log_entry;
  rr_log_entry_t               rp_entry;
  logic     [2:0]              fifo_overflow;
  logic     [2:0]              fifo_almful;
  rr_status_t                  status;

  ////////////////////////////////////////
  // Plain ports onto the channel buses
  ////////////////////////////////////////
  assign sh_a_if.valid = i_sh_a_valid;
  assign sh_a_if.addr  = i_sh_a_addr;
  assign sh_a_if.data  = i_sh_a_data;
  assign o_sh_a_ready  = sh_a_if.ready;
  assign sh_b_if.valid = i_sh_b_valid;
  assign sh_b_if.addr  = i_sh_b_addr;
  assign sh_b_if.data  = i_sh_b_data;
  assign o_sh_b_ready  = sh_b_if.ready;

  assign o_cl_a_valid  = cl_a_if.valid;
  assign o_cl_a_addr   = cl_a_if.addr;
  assign o_cl_a_data   = cl_a_if.data;
  assign cl_a_if.ready = i_cl_a_ready;
  assign o_cl_b_valid  = cl_b_if.valid;
  assign o_cl_b_addr   = cl_b_if.addr;
  assign o_cl_b_data   = cl_b_if.data;
  assign cl_b_if.ready = i_cl_b_ready;

  // Log stream fields
  assign o_log_chan = log_entry.chan;
  assign o_log_addr = log_entry.xfer.addr;
  assign o_log_data = log_entry.xfer.data;

  // Replay stream fields
  assign rp_entry.chan      = i_rp_chan;
  assign rp_entry.xfer.addr = i_rp_addr;
  assign rp_entry.xfer.data = i_rp_data;

  assign o_overflow = status.overflow;
  assign o_almful   = status.almful;

  ////////////////////////////////////////
  // Channel recorders
  ////////////////////////////////////////
  rr_channel_recorder chan_a_recorder (
    .clk        (clk),
    .rstn       (rstn),
    .i_record_en(i_record_en),
    .i_replay_en(i_replay_en),
    .sh         (sh_a_if),
    .rp         (rp_a_if),
    .cl         (cl_a_if),
    .o_log_valid(rec_valid[0]),
    .o_log_xfer (rec_xfer[0]),
    .i_log_pop  (rec_pop[0]),
    .o_almful   (fifo_almful[0]),
    .o_overflow (fifo_overflow[0])
  );

  rr_channel_recorder chan_b_recorder (
    .clk        (clk),
    .rstn       (rstn),
    .i_record_en(i_record_en),
    .i_replay_en(i_replay_en),
    .sh         (sh_b_if),
    .rp         (rp_b_if),
    .cl         (cl_b_if),
    .o_log_valid(rec_valid[1]),
    .o_log_xfer (rec_xfer[1]),
    .i_log_pop  (rec_pop[1]),
    .o_almful   (fifo_almful[1]),
    .o_overflow (fifo_overflow[1])
  );

  // Both channel logs into one tagged stream
  rr_log_merge log_merge (
    .clk        (clk),
    .rstn       (rstn),
    .i_record_en(i_record_en),
    .i_valid    (rec_valid),
    .i_xfer     (rec_xfer),
    .o_pop      (rec_pop),
    .o_log_valid(o_log_valid),
    .i_log_ready(i_log_ready),
    .o_log_entry(log_entry)
  );

  ////////////////////////////////////////
  // Replay and status
  ////////////////////////////////////////
  rr_replayer replayer (
    .clk       (clk),
    .rstn      (rstn),
    .i_rp_valid(i_rp_valid),
    .o_rp_ready(o_rp_ready),
    .i_rp_entry(rp_entry),
    .rp_a      (rp_a_if),
    .rp_b      (rp_b_if),
    .o_almful  (fifo_almful[2]),
    .o_overflow(fifo_overflow[2])
  );

  rr_status status_reg (
    .clk       (clk),
    .rstn      (rstn),
    .i_clr     (i_status_clr),
    .i_overflow(fifo_overflow),
    .i_almful  (fifo_almful),
    .o_status  (status)
  );
endmodule

/* src/rr_status.sv */
`timescale 1ns/1ps

// Sticky overflow and real-time almost-full status
module rr_status (
  input  logic               clk,
  input  logic               rstn,
  input  logic               i_clr,
  input  logic [2:0]         i_overflow,
  input  logic [2:0]         i_almful,
  output rr_pkg::rr_status_t o_status
);
  import rr_pkg::*;

  rr_status_t status_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      status_q <= '0;
    end else begin
      // New overflow pulses survive a clear in the same cycle
      status_q.overflow <= (i_clr ? 3'b000 : status_q.overflow) | i_overflow;
      // Almost-full only follows the FIFOs
      status_q.almful   <= i_almful;
    end
  end

  assign o_status = status_q;
endmodule

/* replay/rr_replayer.sv */
`timescale 1ns/1ps

// Queues the incoming log and drives the replay channels in log order
module rr_replayer (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  i_rp_valid,
  output logic                  o_rp_ready,
  input  rr_pkg::rr_log_entry_t i_rp_entry,
  rr_chan_if.source             rp_a,
  rr_chan_if.source             rp_b,
  output logic                  o_almful,
  output logic                  o_overflow
);
  import rr_pkg::*;

  rr_log_entry_t head;
  logic          live_q;
  logic          fifo_push;
  logic          fifo_pop;
  logic          fifo_empty;
  logic          fifo_full;

  // Input stays closed for the first cycle after reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign o_rp_ready = live_q & ~fifo_full;
  assign fifo_push  = i_rp_valid & o_rp_ready;

  rr_log_fifo #(
    .payload_t(rr_log_entry_t)
  ) replay_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .i_push    (fifo_push),
    .i_data    (i_rp_entry),
    .i_pop     (fifo_pop),
    .o_data    (head),
    .o_empty   (fifo_empty),
    .o_full    (fifo_full),
    .o_almful  (o_almful),
    .o_overflow(o_overflow)
  );

  ////////////////////////////////////////
  // Head routing by tag
  ////////////////////////////////////////
  // Only the head is offered so an A entry blocks any later B entry
  assign rp_a.valid = ~fifo_empty & (head.chan == CHAN_A);
  assign rp_a.addr  = head.xfer.addr;
  assign rp_a.data  = head.xfer.data;

  assign rp_b.valid = ~fifo_empty & (head.chan == CHAN_B);
  assign rp_b.addr  = head.xfer.addr;
  assign rp_b.data  = head.xfer.data;

  // Head leaves once its channel completes
  assign fifo_pop = (rp_a.valid & rp_a.ready) | (rp_b.valid & rp_b.ready);
endmodule

/* record/rr_log_merge.sv */
`timescale 1ns/1ps
`include "rr_defs.svh"

// Round-robin merge of the channel logs into one tagged stream
module rr_log_merge (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  i_record_en,
  input  logic             [`RR_NUM_CHAN-1:0]   i_valid,
  input  rr_pkg::rr_xfer_t [`RR_NUM_CHAN-1:0]   i_xfer,
  output logic             [`RR_NUM_CHAN-1:0]   o_pop,
  output logic                                  o_log_valid,
  input  logic                                  i_log_ready,
  output rr_pkg::rr_log_entry_t                 o_log_entry
);
  import rr_pkg::*;

  rr_chan_id_t prio_q;
  rr_chan_id_t held_chan_q;
  logic        held_q;
  rr_chan_id_t grant;
  logic        accept;

  // A stalled offer keeps its channel so the output stays stable
  always_comb begin
    if (held_q) begin
      grant = held_chan_q;
    end else if (i_valid[prio_q]) begin
      grant = prio_q;
    end else begin
      grant = ~prio_q;
    end
  end

  // Record gate that keeps queued entries waiting while low
  assign o_log_valid = i_record_en & (|i_valid);
  assign accept      = o_log_valid & i_log_ready;

  assign o_log_entry.chan = grant;
  assign o_log_entry.xfer = i_xfer[grant];

  // Pop the granted head on acceptance
  assign o_pop = accept ? (`RR_NUM_CHAN'(1) << grant) : '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      prio_q      <= CHAN_A;
      held_q      <= 1'b0;
      held_chan_q <= CHAN_A;
    end else begin
      held_q      <= o_log_valid & ~i_log_ready;
      held_chan_q <= grant;
      // Turn priority away from the channel just served
      if (accept) begin
        prio_q <= ~grant;
      end
    end
  end
endmodule

/* record/rr_channel_recorder.sv */
`timescale 1ns/1ps

// Source select and transfer logging for one shell-to-circuit channel
module rr_channel_recorder (
  input  logic             clk,
  input  logic             rstn,
  input  logic             i_record_en,
  input  logic             i_replay_en,
  rr_chan_if.sink          sh,
  rr_chan_if.sink          rp,
  rr_chan_if.source        cl,
  output logic             o_log_valid,
  output rr_pkg::rr_xfer_t o_log_xfer,
  input  logic             i_log_pop,
  output logic             o_almful,
  output logic             o_overflow
);
  import rr_pkg::*;

  rr_xfer_t log_xfer;
  logic     log_push;
  logic     log_empty;

  ////////////////////////////////////////
  // Source select toward the circuit
  ////////////////////////////////////////
  // Replay mode hands the circuit to the replayer
  assign cl.valid = i_replay_en ? rp.valid : sh.valid;
  assign cl.addr  = i_replay_en ? rp.addr : sh.addr;
  assign cl.data  = i_replay_en ? rp.data : sh.data;

  // Ready returns to the selected source only
  assign sh.ready = ~i_replay_en & cl.ready;
  assign rp.ready = i_replay_en & cl.ready;

  ////////////////////////////////////////
  // Logging
  ////////////////////////////////////////
  // Circuit side is logged so replayed traffic is recorded too
  assign log_push      = i_record_en & cl.valid & cl.ready;
  assign log_xfer.addr = cl.addr;
  assign log_xfer.data = cl.data;

  // Logging never stalls the channel
  rr_log_fifo #(
    .payload_t(rr_xfer_t)
  ) log_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .i_push    (log_push),
    .i_data    (log_xfer),
    .i_pop     (i_log_pop),
    .o_data    (o_log_xfer),
    .o_empty   (log_empty),
    .o_full    (),
    .o_almful  (o_almful),
    .o_overflow(o_overflow)
  );

  assign o_log_valid = ~log_empty;
endmodule

/* src/rr_log_fifo.sv */
`timescale 1ns/1ps
`include "rr_defs.svh"

// Register-array FIFO shared by the log and replay paths
module rr_log_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     i_push,
  input  payload_t i_data,
  input  logic     i_pop,
  output payload_t o_data,
  output logic     o_empty,
  output logic     o_full,
  output logic     o_almful,
  output logic     o_overflow
);
  localparam int DEPTH = `RR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign o_empty  = (count_q == '0);
  assign o_full   = (count_q == CNT_W'(DEPTH));
  assign o_almful = (count_q >= CNT_W'(`RR_ALMFUL_LEVEL));

  // A push into a full FIFO is lost
  assign do_push    = i_push & ~o_full;
  assign do_pop     = i_pop & ~o_empty;
  assign o_overflow = i_push & o_full;

  // Head is always on the output
  assign o_data = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  ////////////////////////////////////////
  // Pointers and fill count
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Explicit wrap so the depth need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end
endmodule

/* common/rr_chan_if.sv */
`timescale 1ns/1ps
`include "rr_defs.svh"

// Valid/ready write channel with one address and one data word
interface rr_chan_if;
  logic                  valid;
  logic                  ready;
  logic [`RR_ADDR_W-1:0] addr;
  logic [`RR_DATA_W-1:0] data;

  // Source holds valid and payload stable until ready
  modport source (
    output valid,
    output addr,
    output data,
    input  ready
  );

  // Sink answers with ready only
  modport sink (
    input  valid,
    input  addr,
    input  data,
    output ready
  );
endinterface

/* common/rr_pkg.sv */
`include "rr_defs.svh"

package rr_pkg;

  // Channel tag carried by every log entry
  typedef logic rr_chan_id_t;

  localparam rr_chan_id_t CHAN_A = 1'b0;
  localparam rr_chan_id_t CHAN_B = 1'b1;

  // One completed write transfer
  typedef struct packed {
    logic [`RR_ADDR_W-1:0] addr;
    logic [`RR_DATA_W-1:0] data;
  } rr_xfer_t;

  // Transfer plus the channel it was seen on
  typedef struct packed {
    rr_chan_id_t chan;
    rr_xfer_t    xfer;
  } rr_log_entry_t;

  // Bit 0 is recorder A, bit 1 recorder B, bit 2 the replayer
  typedef struct packed {
    logic [2:0] overflow;
    logic [2:0] almful;
  } rr_status_t;

endpackage

/* common/rr_defs.svh */
`ifndef RR_DEFS_SVH
`define RR_DEFS_SVH

// Channel payload widths
`define RR_ADDR_W 16
`define RR_DATA_W 32

// Entries held by each log FIFO and by the replay FIFO
`define RR_FIFO_DEPTH 8

// Fill count at which almost-full is raised
`define RR_ALMFUL_LEVEL 6

// Shell-to-circuit write channels A and B
`define RR_NUM_CHAN 2

`endif
